// File: hdl/tpu_params.svh
`ifndef TPU_PARAMS_SVH
`define TPU_PARAMS_SVH

// row geometry
`define DESIGN_SIZE 4
`define DWIDTH 8
`define AWIDTH 7

// register bus
`define REG_ADDRWIDTH 8
`define REG_DATAWIDTH 32

// fixed point position of inv_var
`define NORM_FRAC_BITS 4

// register byte offsets
`define REG_CTRL 8'h00
`define REG_STATUS 8'h04
`define REG_NORM 8'h08
`define REG_ADDR_A 8'h0C
`define REG_ADDR_C 8'h10
`define REG_STRIDE_C 8'h14
`define REG_NUM_ROWS 8'h18
`define REG_MASK 8'h1C

`endif

// File: hdl/tpu_pkg.sv
`include "tpu_params.svh"

package tpu_pkg;

  typedef logic signed [`DWIDTH-1:0] lane_t;

  // lane 0 sits in the low bits
  typedef lane_t [`DESIGN_SIZE-1:0] row_t;

  typedef logic [`AWIDTH-1:0] addr_t;
  typedef logic [`DESIGN_SIZE-1:0] mask_t;

  typedef logic [`REG_ADDRWIDTH-1:0] reg_addr_t;
  typedef logic [`REG_DATAWIDTH-1:0] reg_data_t;

endpackage

// File: hdl/buffer_ram.sv
`timescale 1ns/10ps
`include "tpu_params.svh"

module buffer_ram (
  input  logic           clk,
  input  tpu_pkg::addr_t host_addr,
  input  tpu_pkg::row_t  host_wdata,
  input  logic           host_we,
  output tpu_pkg::row_t  host_rdata,
  input  logic           rd_en,
  input  tpu_pkg::addr_t rd_addr,
  output tpu_pkg::row_t  rd_data,
  input  logic           wr_en,
  input  tpu_pkg::addr_t wr_addr,
  input  tpu_pkg::row_t  wr_data
);

  tpu_pkg::row_t mem [2**`AWIDTH];
  logic          host_blocked;

  // engine write takes the address when both hit it
  assign host_blocked = wr_en && (wr_addr == host_addr);

  always_ff @(posedge clk) begin
    if (host_we && !host_blocked)
      mem[host_addr] <= host_wdata;
    if (wr_en)
      mem[wr_addr] <= wr_data;
    host_rdata <= mem[host_addr];
    if (rd_en)
      rd_data <= mem[rd_addr];
  end

  // host traffic must stay off the rows the engine is writing
  assert property (@(posedge clk) !(host_we && wr_en && (host_addr == wr_addr)))
    else $error("host and engine write row %0d in the same cycle", wr_addr);

endmodule

// File: hdl/tpu_regs.sv
`timescale 1ns/10ps
`include "tpu_params.svh"

module tpu_regs (
  input  logic                clk,
  input  logic                reset,
  input  tpu_pkg::reg_addr_t  paddr,
  input  logic                pwrite,
  input  logic                psel,
  input  logic                penable,
  input  tpu_pkg::reg_data_t  pwdata,
  output tpu_pkg::reg_data_t  prdata,
  output logic                pready,
  output logic                start,
  output logic                enable_norm,
  output logic                enable_activation,
  output tpu_pkg::lane_t      mean,
  output logic [`DWIDTH-1:0]  inv_var,
  output tpu_pkg::addr_t      addr_a,
  output tpu_pkg::addr_t      addr_c,
  output tpu_pkg::addr_t      stride_c,
  output tpu_pkg::addr_t      num_rows,
  output tpu_pkg::mask_t      lane_mask,
  input  logic                busy,
  input  logic                done
);

  logic wr_access;
  logic start_req;
  logic done_sticky;

  // no wait states, every access cycle completes
  assign pready    = psel && penable;
  assign wr_access = psel && penable && pwrite;
  assign start_req = wr_access && (paddr == `REG_CTRL) && pwdata[0];

  //////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      start             <= 1'b0;
      done_sticky       <= 1'b0;
      enable_norm       <= 1'b0;
      enable_activation <= 1'b0;
      mean              <= '0;
      inv_var           <= '0;
      addr_a            <= '0;
      addr_c            <= '0;
      stride_c          <= '0;
      num_rows          <= '0;
      lane_mask         <= '0;
    end else begin
      start <= start_req;
      // a new run clears the previous done
      if (start_req)
        done_sticky <= 1'b0;
      else if (done)
        done_sticky <= 1'b1;
      if (wr_access) begin
        case (paddr)
          `REG_CTRL: begin
            enable_norm       <= pwdata[1];
            enable_activation <= pwdata[2];
          end
          `REG_NORM: begin
            mean    <= pwdata[`DWIDTH-1:0];
            inv_var <= pwdata[2*`DWIDTH-1:`DWIDTH];
          end
          `REG_ADDR_A:   addr_a    <= pwdata[`AWIDTH-1:0];
          `REG_ADDR_C:   addr_c    <= pwdata[`AWIDTH-1:0];
          `REG_STRIDE_C: stride_c  <= pwdata[`AWIDTH-1:0];
          `REG_NUM_ROWS: num_rows  <= pwdata[`AWIDTH-1:0];
          `REG_MASK:     lane_mask <= pwdata[`DESIGN_SIZE-1:0];
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////
  always_comb begin
    prdata = '0;
    case (paddr)
      `REG_CTRL:     prdata[2:0] = {enable_activation, enable_norm, 1'b0};
      `REG_STATUS:   prdata[1:0] = {busy, done_sticky};
      `REG_NORM:     prdata[2*`DWIDTH-1:0] = {inv_var, mean};
      `REG_ADDR_A:   prdata[`AWIDTH-1:0] = addr_a;
      `REG_ADDR_C:   prdata[`AWIDTH-1:0] = addr_c;
      `REG_STRIDE_C: prdata[`AWIDTH-1:0] = stride_c;
      `REG_NUM_ROWS: prdata[`AWIDTH-1:0] = num_rows;
      `REG_MASK:     prdata[`DESIGN_SIZE-1:0] = lane_mask;
      default: ;
    endcase
  end

  assert property (@(posedge clk) disable iff (reset) penable |-> psel)
    else $error("penable seen without psel");

endmodule

// File: hdl/tpu_control.sv
`timescale 1ns/10ps

module tpu_control (
  input  logic           clk,
  input  logic           reset,
  input  logic           start,
  input  tpu_pkg::addr_t addr_a,
  input  tpu_pkg::addr_t addr_c,
  input  tpu_pkg::addr_t stride_c,
  input  tpu_pkg::addr_t num_rows,
  input  logic           out_valid,
  output logic           rd_en,
  output tpu_pkg::addr_t rd_addr,
  output tpu_pkg::addr_t wr_addr,
  output logic           busy,
  output logic           done
);

  tpu_pkg::addr_t rd_cnt;
  tpu_pkg::addr_t wr_cnt;
  logic           launch;

  // a start during a run is dropped
  assign launch = start && !busy;

  //////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_en  <= 1'b0;
      rd_cnt <= '0;
      wr_cnt <= '0;
      busy   <= 1'b0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (launch) begin
        busy   <= 1'b1;
        rd_en  <= (num_rows != '0);
        rd_cnt <= 1;
        wr_cnt <= '0;
        // empty run finishes right away
        done   <= (num_rows == '0);
      end else if (done) begin
        busy <= 1'b0;
      end
      // rd_cnt counts the read issued in this cycle
      if (rd_en) begin
        if (rd_cnt == num_rows)
          rd_en <= 1'b0;
        else
          rd_cnt <= rd_cnt + 1'b1;
      end
      if (out_valid) begin
        wr_cnt <= wr_cnt + 1'b1;
        if (wr_cnt + 1'b1 == num_rows)
          done <= 1'b1;
      end
    end
  end

  // row addresses, loaded at launch
  always_ff @(posedge clk) begin
    if (launch) begin
      rd_addr <= addr_a;
      wr_addr <= addr_c;
    end else begin
      if (rd_en)
        rd_addr <= rd_addr + 1'b1;
      if (out_valid)
        wr_addr <= wr_addr + stride_c;
    end
  end

  // pipeline results only arrive inside a run
  assert property (@(posedge clk) disable iff (reset) out_valid |-> busy)
    else $error("write-back while the sequencer is idle");

endmodule

// File: hdl/norm_act_pipe.sv
`timescale 1ns/10ps
`include "tpu_params.svh"

module norm_act_pipe (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  input  tpu_pkg::row_t      in_row,
  input  logic               enable_norm,
  input  logic               enable_activation,
  input  tpu_pkg::lane_t     mean,
  input  logic [`DWIDTH-1:0] inv_var,
  input  tpu_pkg::mask_t     lane_mask,
  output logic               out_valid,
  output tpu_pkg::row_t      out_row
);

  localparam int LANE_MAX = 2**(`DWIDTH-1) - 1;
  localparam int LANE_MIN = -(2**(`DWIDTH-1));

  logic          s1_valid;
  tpu_pkg::row_t s1_row;

  // (x - mean) * inv_var >>> frac, clamped to the lane range
  function automatic tpu_pkg::lane_t norm_lane(input tpu_pkg::lane_t x);
    logic signed [`DWIDTH:0]     diff;
    logic signed [2*`DWIDTH+1:0] prod;
    logic signed [2*`DWIDTH+1:0] shifted;
    diff    = x - mean;
    prod    = diff * $signed({1'b0, inv_var});
    shifted = prod >>> `NORM_FRAC_BITS;
    if (shifted > LANE_MAX)
      return tpu_pkg::lane_t'(LANE_MAX);
    else if (shifted < LANE_MIN)
      return tpu_pkg::lane_t'(LANE_MIN);
    else
      return tpu_pkg::lane_t'(shifted);
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `DESIGN_SIZE; i++) begin
      // stage 1
      s1_row[i] <= enable_norm ? norm_lane(in_row[i]) : in_row[i];
      // stage 2 applies relu then the lane mask
      if (!lane_mask[i] || (enable_activation && s1_row[i] < 0))
        out_row[i] <= '0;
      else
        out_row[i] <= s1_row[i];
    end
  end

  assert property (@(posedge clk) disable iff (reset) in_valid |-> !$isunknown(in_row))
    else $error("row entered the pipeline with unknown lanes");

endmodule

// File: hdl/tpu_top.sv
`timescale 1ns/10ps
`include "tpu_params.svh"

module tpu_top (
  input  logic               clk,
  input  logic               reset,
  input  tpu_pkg::reg_addr_t paddr,
  input  logic               pwrite,
  input  logic               psel,
  input  logic               penable,
  input  tpu_pkg::reg_data_t pwdata,
  output tpu_pkg::reg_data_t prdata,
  output logic               pready,
  input  tpu_pkg::addr_t     host_addr,
  input  tpu_pkg::row_t      host_wdata,
  input  logic               host_we,
  output tpu_pkg::row_t      host_rdata
);

  logic               start;
  logic               enable_norm;
  logic               enable_activation;
  tpu_pkg::lane_t     mean;
  logic [`DWIDTH-1:0] inv_var;
  tpu_pkg::addr_t     addr_a;
  tpu_pkg::addr_t     addr_c;
  tpu_pkg::addr_t     stride_c;
  tpu_pkg::addr_t     num_rows;
  tpu_pkg::mask_t     lane_mask;
  logic               busy;
  logic               done;
  logic               rd_en;
  tpu_pkg::addr_t     rd_addr;
  tpu_pkg::addr_t     wr_addr;
  tpu_pkg::row_t      rd_data;
  logic               in_valid;
  logic               out_valid;
  tpu_pkg::row_t      out_row;

  // read data comes back a cycle after rd_en
  always_ff @(posedge clk) begin
    if (reset)
      in_valid <= 1'b0;
    else
      in_valid <= rd_en;
  end

  //////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////
  tpu_regs u_regs (
    .clk(clk), .reset(reset),
    .paddr(paddr), .pwrite(pwrite), .psel(psel), .penable(penable),
    .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .start(start), .enable_norm(enable_norm), .enable_activation(enable_activation),
    .mean(mean), .inv_var(inv_var),
    .addr_a(addr_a), .addr_c(addr_c), .stride_c(stride_c), .num_rows(num_rows),
    .lane_mask(lane_mask), .busy(busy), .done(done)
  );

  tpu_control u_control (
    .clk(clk), .reset(reset), .start(start),
    .addr_a(addr_a), .addr_c(addr_c), .stride_c(stride_c), .num_rows(num_rows),
    .out_valid(out_valid), .rd_en(rd_en), .rd_addr(rd_addr), .wr_addr(wr_addr),
    .busy(busy), .done(done)
  );

  norm_act_pipe u_pipe (
    .clk(clk), .reset(reset), .in_valid(in_valid), .in_row(rd_data),
    .enable_norm(enable_norm), .enable_activation(enable_activation),
    .mean(mean), .inv_var(inv_var), .lane_mask(lane_mask),
    .out_valid(out_valid), .out_row(out_row)
  );

  buffer_ram u_ram (
    .clk(clk),
    .host_addr(host_addr), .host_wdata(host_wdata), .host_we(host_we),
    .host_rdata(host_rdata),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
    .wr_en(out_valid), .wr_addr(wr_addr), .wr_data(out_row)
  );

endmodule

// File: tb/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
  if (expected !== actual) begin
    errors++;
    $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    $display("Finished with errors");
    $fatal(1, "stopping at the first mismatch");
  end
endtask

//////////////////////////////////////////////////
// bus and host port
//////////////////////////////////////////////////
task automatic bus_write(input tpu_pkg::reg_addr_t a, input tpu_pkg::reg_data_t d);
  @(posedge clk);
  paddr   <= a;
  pwrite  <= 1'b1;
  psel    <= 1'b1;
  penable <= 1'b0;
  pwdata  <= d;
  @(posedge clk);
  penable <= 1'b1;
  @(posedge clk);
  psel    <= 1'b0;
  penable <= 1'b0;
  pwrite  <= 1'b0;
endtask

task automatic bus_read(input tpu_pkg::reg_addr_t a, output tpu_pkg::reg_data_t d);
  @(posedge clk);
  paddr   <= a;
  pwrite  <= 1'b0;
  psel    <= 1'b1;
  penable <= 1'b0;
  @(posedge clk);
  penable <= 1'b1;
  @(negedge clk);
  check("pready", 32'd1, {31'd0, pready});
  d = prdata;
  @(posedge clk);
  psel    <= 1'b0;
  penable <= 1'b0;
endtask

task automatic host_write(input tpu_pkg::addr_t a, input tpu_pkg::row_t d);
  @(posedge clk);
  host_addr  <= a;
  host_wdata <= d;
  host_we    <= 1'b1;
  @(posedge clk);
  host_we    <= 1'b0;
  img[a] = d;
endtask

task automatic host_read(input tpu_pkg::addr_t a, output tpu_pkg::row_t d);
  @(posedge clk);
  host_addr <= a;
  @(posedge clk);
  @(negedge clk);
  d = host_rdata;
endtask

//////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////
function automatic tpu_pkg::lane_t norm_ref(input tpu_pkg::lane_t x, input tpu_pkg::lane_t m,
                                            input logic [7:0] inv);
  integer xi;
  integer mi;
  integer vi;
  integer p;
  xi = x;
  mi = m;
  vi = inv;
  p = ((xi - mi) * vi) >>> `NORM_FRAC_BITS;
  if (p > 127)
    p = 127;
  if (p < -128)
    p = -128;
  return tpu_pkg::lane_t'(p);
endfunction

function automatic tpu_pkg::row_t expected_row(input tpu_pkg::row_t x, input logic en_norm,
                                               input logic en_act, input tpu_pkg::lane_t m,
                                               input logic [7:0] inv, input tpu_pkg::mask_t mask);
  tpu_pkg::row_t r;
  for (int i = 0; i < `DESIGN_SIZE; i++) begin
    r[i] = en_norm ? norm_ref(x[i], m, inv) : x[i];
    if ((en_act && r[i] < 0) || !mask[i])
      r[i] = '0;
  end
  return r;
endfunction

task automatic compare_rows(input string name, input tpu_pkg::addr_t lo, input int count);
  tpu_pkg::row_t  got;
  tpu_pkg::addr_t a;
  a = lo;
  for (int k = 0; k < count; k++) begin
    host_read(a, got);
    check(name, img[a], got);
    a = a + 1'b1;
  end
endtask

// configure, start, poll for done and check the whole output span
task automatic run_rows(input string name, input tpu_pkg::addr_t a, input tpu_pkg::addr_t c,
                        input tpu_pkg::addr_t stride, input tpu_pkg::addr_t n,
                        input logic en_norm, input logic en_act, input tpu_pkg::lane_t m,
                        input logic [7:0] inv, input tpu_pkg::mask_t mask);
  tpu_pkg::reg_data_t st;
  tpu_pkg::addr_t     dst;
  bus_write(`REG_ADDR_A, a);
  bus_write(`REG_ADDR_C, c);
  bus_write(`REG_STRIDE_C, stride);
  bus_write(`REG_NUM_ROWS, n);
  bus_write(`REG_NORM, {16'd0, inv, m});
  bus_write(`REG_MASK, mask);
  for (int i = 0; i < n; i++) begin
    dst = tpu_pkg::addr_t'(c + i * stride);
    img[dst] = expected_row(img[tpu_pkg::addr_t'(a + i)], en_norm, en_act, m, inv, mask);
  end
  bus_write(`REG_CTRL, {29'd0, en_act, en_norm, 1'b1});
  // empty run is already done, others are still busy with done cleared
  bus_read(`REG_STATUS, st);
  check({name, " status after start"}, (n == 0) ? 32'd1 : 32'd2, st);
  do
    bus_read(`REG_STATUS, st);
  while (!st[0]);
  check({name, " status after run"}, 32'd1, st);
  compare_rows(name, c, (n == 0) ? 1 : (n - 1) * stride + 2);
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////
task automatic write_read(input string name, input tpu_pkg::reg_addr_t a,
                          input tpu_pkg::reg_data_t wval, input tpu_pkg::reg_data_t expected);
  tpu_pkg::reg_data_t got;
  bus_write(a, wval);
  bus_read(a, got);
  check(name, expected, got);
endtask

task automatic test_registers();
  write_read("ctrl", `REG_CTRL, 32'h7, 32'h6);
  write_read("norm", `REG_NORM, 32'h0000_A5C3, 32'h0000_A5C3);
  write_read("addr_a", `REG_ADDR_A, 32'h55, 32'h55);
  write_read("addr_c", `REG_ADDR_C, 32'h2A, 32'h2A);
  write_read("stride_c", `REG_STRIDE_C, 32'h13, 32'h13);
  write_read("num_rows", `REG_NUM_ROWS, 32'h61, 32'h61);
  write_read("mask", `REG_MASK, 32'hA, 32'hA);
  write_read("unmapped", 8'h20, 32'hDEAD_BEEF, 32'h0);
  write_read("ctrl clear", `REG_CTRL, 32'h0, 32'h0);
endtask

task automatic test_host_port();
  tpu_pkg::row_t  got;
  tpu_pkg::addr_t a;
  for (int k = 0; k < 2**`AWIDTH; k++)
    host_write(tpu_pkg::addr_t'(k), tpu_pkg::row_t'($random(seed)));
  for (int k = 0; k < 16; k++) begin
    a = tpu_pkg::addr_t'($random(seed));
    host_read(a, got);
    check("host port", img[a], got);
  end
endtask

task automatic test_bypass();
  run_rows("bypass", 7'd0, 7'd40, 7'd3, 7'd8, 1'b0, 1'b0, 8'sd0, 8'd0, 4'hF);
endtask

task automatic test_norm();
  // saturation both ways with mean 5 and inv_var 3.0
  host_write(7'd8, {8'sd127, -8'sd128, 8'sd20, -8'sd20});
  host_write(7'd9, {8'sd5, 8'sd6, 8'sd4, 8'sd0});
  host_write(7'd10, {8'sd60, -8'sd60, 8'sd45, -8'sd41});
  host_write(7'd11, {8'sd1, -8'sd1, 8'sd100, -8'sd100});
  run_rows("norm", 7'd8, 7'd64, 7'd1, 7'd4, 1'b1, 1'b0, 8'sd5, 8'h30, 4'hF);
  run_rows("norm mask", 7'd8, 7'd70, 7'd2, 7'd4, 1'b1, 1'b0, 8'sd5, 8'h30, 4'h5);
endtask

task automatic test_norm_relu();
  run_rows("norm relu", 7'd16, 7'd80, 7'd2, 7'd16, 1'b1, 1'b1, -8'sd7, 8'h1C, 4'hF);
endtask

task automatic test_status();
  run_rows("status", 7'd0, 7'd112, 7'd1, 7'd4, 1'b0, 1'b1, 8'sd0, 8'd0, 4'hF);
  run_rows("empty run", 7'd0, 7'd120, 7'd1, 7'd0, 1'b0, 1'b0, 8'sd0, 8'd0, 4'hF);
  run_rows("back to back 1", 7'd4, 7'd116, 7'd1, 7'd3, 1'b0, 1'b0, 8'sd0, 8'd0, 4'hF);
  run_rows("back to back 2", 7'd4, 7'd122, 7'd2, 7'd3, 1'b1, 1'b1, 8'sd12, 8'h24, 4'hE);
endtask

`endif

// File: tb/tb_tpu.sv
`timescale 1ns/10ps
`include "tpu_params.svh"

module tb_tpu;

  // the tests take roughly 1000 cycles, most of it host fill and row readback
  localparam int TIMEOUT_CYCLES = 3000;

  logic               clk;
  logic               reset;
  tpu_pkg::reg_addr_t paddr;
  logic               pwrite;
  logic               psel;
  logic               penable;
  tpu_pkg::reg_data_t pwdata;
  tpu_pkg::reg_data_t prdata;
  logic               pready;
  tpu_pkg::addr_t     host_addr;
  tpu_pkg::row_t      host_wdata;
  logic               host_we;
  tpu_pkg::row_t      host_rdata;

  // expected contents of the row buffer
  tpu_pkg::row_t img [2**`AWIDTH];
  integer        seed;
  integer        errors;
  integer        cycles = 0;

  tpu_top u_dut (
    .clk(clk), .reset(reset),
    .paddr(paddr), .pwrite(pwrite), .psel(psel), .penable(penable),
    .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .host_addr(host_addr), .host_wdata(host_wdata), .host_we(host_we),
    .host_rdata(host_rdata)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Finished with errors");
      $fatal(1, "the run timed out after %0d cycles", TIMEOUT_CYCLES);
    end
  end

  `include "tb_tasks.svh"

  initial begin
    seed       = 2;
    errors     = 0;
    reset      = 1'b1;
    paddr      = '0;
    pwrite     = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwdata     = '0;
    host_addr  = '0;
    host_wdata = '0;
    host_we    = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    test_registers();
    test_host_port();
    test_bypass();
    test_norm();
    test_norm_relu();
    test_status();

    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+hdl
+incdir+tb
hdl/tpu_pkg.sv
hdl/buffer_ram.sv
hdl/tpu_regs.sv
hdl/tpu_control.sv
hdl/norm_act_pipe.sv
hdl/tpu_top.sv
tb/tb_tpu.sv

// File: Bender.yml
package:
  name: tpu_postproc

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/tpu_pkg.sv
      - hdl/buffer_ram.sv
      - hdl/tpu_regs.sv
      - hdl/tpu_control.sv
      - hdl/norm_act_pipe.sv
      - hdl/tpu_top.sv
  - target: test
    include_dirs:
      - hdl
      - tb
    files:
      - tb/tb_tpu.sv
